/* common/dna_cfg.svh */
`ifndef DNA_CFG_SVH
`define DNA_CFG_SVH

// =========================================================================
// Identifier and counter sizes
// =========================================================================
`define DNA_WIDTH       96      // Die identifier bits
`define DNA_CNT_WIDTH   7       // Enough for 0..95
`define DNA_SIM_VALUE   96'hBBAA_9988_7766_5544_3322_1100

// =========================================================================
// AXI4-Lite bus and register map
// =========================================================================
`define AXIL_ADDR_WIDTH 4
`define AXIL_DATA_WIDTH 32

`define DNA_REG_ID_LO       4'h0    // Bits 31:0
`define DNA_REG_ID_MID      4'h4    // Bits 63:32
`define DNA_REG_ID_HI       4'h8    // Bits 95:64
`define DNA_REG_CTRL_STATUS 4'hC    // Valid/busy on read, restart on write

`endif

/* common/dna_pkg.sv */
`include "dna_cfg.svh"

package dna_pkg;

    // =========================================================================
    // Reader sequencing
    // =========================================================================

    // Load one cycle, shift DNA_WIDTH cycles, then hold
    typedef enum logic [1:0] {
        LOAD  = 2'd0,
        SHIFT = 2'd1,
        DONE  = 2'd2
    } read_state_e;

    // =========================================================================
    // Software view
    // =========================================================================

    // Word-aligned register offsets
    typedef enum logic [`AXIL_ADDR_WIDTH-1:0] {
        ID_LO       = `DNA_REG_ID_LO,
        ID_MID      = `DNA_REG_ID_MID,
        ID_HI       = `DNA_REG_ID_HI,
        CTRL_STATUS = `DNA_REG_CTRL_STATUS
    } reg_addr_e;

    // Only the two responses this slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // CTRL_STATUS bit positions
    localparam int unsigned STATUS_VALID_BIT = 0;
    localparam int unsigned STATUS_BUSY_BIT  = 1;
    localparam int unsigned CTRL_RESTART_BIT = 0;

endpackage

/* common/dna_shift_if.sv */
`timescale 1ns/1ns

// Strobes shared by the reader FSM, bit counter and capture register
interface dna_shift_if;

    logic load;     // Load identity port, clear counter and capture
    logic shift;    // One bit per cycle
    logic last;     // Counter sits on the final bit
    logic done;     // Identifier complete

    modport fsm (
        output load,
        output shift,
        output done,
        input  last
    );

    modport counter (
        input  load,
        input  shift,
        output last
    );

    modport capture (
        input  load,
        input  shift
    );

endinterface

/* dna_reader/dna_read_fsm.sv */
`timescale 1ns/1ns

module dna_read_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 restart,   // One-cycle request from software
    dna_shift_if.fsm             ctl,
    output dna_pkg::read_state_e state
);

    dna_pkg::read_state_e next_state;

    // =========================================================================
    // State register
    // =========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dna_pkg::LOAD;  // Read starts straight out of reset
        end else begin
            state <= next_state;
        end
    end

    // =========================================================================
    // Next state and strobes
    // =========================================================================
    always_comb begin
        next_state = state;
        ctl.load   = 1'b0;
        ctl.shift  = 1'b0;
        ctl.done   = 1'b0;

        case (state)
            dna_pkg::LOAD: begin
                ctl.load   = 1'b1;               // Single cycle
                next_state = dna_pkg::SHIFT;
            end

            dna_pkg::SHIFT: begin
                ctl.shift = 1'b1;
                if (ctl.last) begin              // 96th shift happens this edge
                    next_state = dna_pkg::DONE;
                end
            end

            dna_pkg::DONE: begin
                ctl.done = 1'b1;
                if (restart) begin
                    next_state = dna_pkg::LOAD;  // Re-read on request
                end
            end

            default: begin
                next_state = dna_pkg::LOAD;      // Recover from bad encoding
            end
        endcase
    end

    // Restart outside DONE falls through the cases above untouched

endmodule

/* dna_reader/dna_bit_counter.sv */
`timescale 1ns/1ns
`include "dna_cfg.svh"

module dna_bit_counter (
    input  logic         clk,
    input  logic         reset,
    dna_shift_if.counter ctl
);

    // Index of the final identifier bit
    localparam logic [`DNA_CNT_WIDTH-1:0] LAST_COUNT = `DNA_WIDTH - 1;

    logic [`DNA_CNT_WIDTH-1:0] count;   // Bits shifted so far

    // =========================================================================
    // Shift count
    // =========================================================================
    always_ff @(posedge clk) begin
        if (reset || ctl.load) begin
            count <= '0;                    // Fresh read
        end else if (ctl.shift) begin
            count <= count + 1'b1;
        end
    end

    // High during the cycle of the last shift
    // Stays high in DONE, the FSM ignores it there
    assign ctl.last = (count == LAST_COUNT);

endmodule

/* dna_reader/dna_capture_reg.sv */
`timescale 1ns/1ns
`include "dna_cfg.svh"

module dna_capture_reg (
    input  logic                  clk,
    input  logic                  reset,
    dna_shift_if.capture          ctl,
    input  logic                  serial_in,   // From identity port, LSB first
    output logic [`DNA_WIDTH-1:0] dna_value
);

    // =========================================================================
    // Capture shift register
    // =========================================================================

    // New bit enters at the top and walks down one place per shift
    // After DNA_WIDTH shifts the first bit out of the port sits at bit 0
    always_ff @(posedge clk) begin
        if (reset || ctl.load) begin
            dna_value <= '0;
        end else if (ctl.shift) begin
            dna_value <= {serial_in, dna_value[`DNA_WIDTH-1:1]};
        end
    end

    // Value is held once shifting stops

endmodule

/* src/dna_port_model.sv */
`timescale 1ns/1ns
`include "dna_cfg.svh"

// Behavioral stand-in for the silicon identity primitive
module dna_port_model #(
    parameter logic [`DNA_WIDTH-1:0] SIM_VALUE = `DNA_SIM_VALUE
) (
    input  logic clk,
    input  logic read,        // Load the stored identifier
    input  logic shift,       // Shift one bit toward serial_out
    output logic serial_out
);

    // =========================================================================
    // Identifier shift register
    // =========================================================================
    logic [`DNA_WIDTH-1:0] dna_sreg;

    // Holds the identifier loaded by the last read
    always_ff @(posedge clk) begin
        if (read) begin
            dna_sreg <= SIM_VALUE;
        end else if (shift) begin
            dna_sreg <= {1'b0, dna_sreg[`DNA_WIDTH-1:1]};  // Zero fill from the top
        end
    end

    // =========================================================================
    // Serial output
    // =========================================================================

    // Current LSB always visible
    // Consumer samples it on the same edge that shifts
    assign serial_out = dna_sreg[0];

    // Read has priority over shift, matching the primitive

endmodule

/* src/dna_axil_regs.sv */
`timescale 1ns/1ns
`include "dna_cfg.svh"

module dna_axil_regs (
    input  logic                        clk,
    input  logic                        reset,

    // Write address and data
    input  logic [`AXIL_ADDR_WIDTH-1:0] s_awaddr,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  logic [`AXIL_DATA_WIDTH-1:0] s_wdata,
    input  logic                        s_wvalid,
    output logic                        s_wready,

    // Write response
    output dna_pkg::axi_resp_e          s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,

    // Read address and data
    input  logic [`AXIL_ADDR_WIDTH-1:0] s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [`AXIL_DATA_WIDTH-1:0] s_rdata,
    output dna_pkg::axi_resp_e          s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready,

    // Reader side
    input  logic [`DNA_WIDTH-1:0]       dna_value,
    input  logic                        valid,
    input  logic                        busy,
    output logic                        restart    // One-cycle pulse
);

    localparam int unsigned DW = `AXIL_DATA_WIDTH;

    logic               wr_accept;    // Take address and data next cycle
    logic               wr_fire;      // Both write handshakes this edge
    logic               wr_is_ctrl;
    logic               rd_accept;
    logic               rd_fire;
    logic [DW-1:0]      rd_data;
    dna_pkg::axi_resp_e rd_resp;

    // =========================================================================
    // Write channel
    // =========================================================================
    assign wr_accept  = s_awvalid && s_wvalid && !s_awready && !s_bvalid;
    assign wr_fire    = s_awready && s_awvalid;   // wready rises with awready
    assign wr_is_ctrl = (dna_pkg::reg_addr_e'(s_awaddr) == dna_pkg::CTRL_STATUS);

    always_ff @(posedge clk) begin
        if (reset) begin
            s_awready <= 1'b0;
            s_wready  <= 1'b0;
            s_bvalid  <= 1'b0;
            restart   <= 1'b0;
        end else begin
            s_awready <= wr_accept;       // Low while a response is pending
            s_wready  <= wr_accept;
            restart   <= wr_fire && wr_is_ctrl && s_wdata[dna_pkg::CTRL_RESTART_BIT];
            if (wr_fire) begin
                s_bvalid <= 1'b1;
            end else if (s_bvalid && s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    // Only CTRL_STATUS is writable
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            s_bresp <= wr_is_ctrl ? dna_pkg::OKAY : dna_pkg::SLVERR;
        end
    end

    // =========================================================================
    // Read decode
    // =========================================================================
    always_comb begin
        rd_data = '0;
        rd_resp = dna_pkg::OKAY;
        case (dna_pkg::reg_addr_e'(s_araddr))
            dna_pkg::ID_LO:  rd_data = valid ? dna_value[DW-1:0] : '0;
            dna_pkg::ID_MID: rd_data = valid ? dna_value[2*DW-1:DW] : '0;
            dna_pkg::ID_HI:  rd_data = valid ? dna_value[3*DW-1:2*DW] : '0;
            dna_pkg::CTRL_STATUS: begin
                rd_data[dna_pkg::STATUS_VALID_BIT] = valid;
                rd_data[dna_pkg::STATUS_BUSY_BIT]  = busy;
            end
            default: rd_resp = dna_pkg::SLVERR;   // Unmapped, data stays zero
        endcase
    end

    // =========================================================================
    // Read channel
    // =========================================================================
    assign rd_accept = s_arvalid && !s_arready && !s_rvalid;
    assign rd_fire   = s_arready && s_arvalid;

    always_ff @(posedge clk) begin
        if (reset) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
        end else begin
            s_arready <= rd_accept;
            if (rd_fire) begin
                s_rvalid <= 1'b1;         // Data one cycle after address
            end else if (s_rvalid && s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

    // Data captured at address handshake, stable until rready
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_rdata <= rd_data;
            s_rresp <= rd_resp;
        end
    end

endmodule

/* src/dna_id_top.sv */
`timescale 1ns/1ns
`include "dna_cfg.svh"

module dna_id_top (
    input  logic                        clk,
    input  logic                        reset,

    // AXI4-Lite slave
    input  logic [`AXIL_ADDR_WIDTH-1:0] s_awaddr,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  logic [`AXIL_DATA_WIDTH-1:0] s_wdata,
    input  logic                        s_wvalid,
    output logic                        s_wready,
    output logic [1:0]                  s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,
    input  logic [`AXIL_ADDR_WIDTH-1:0] s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [`AXIL_DATA_WIDTH-1:0] s_rdata,
    output logic [1:0]                  s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready,

    output logic                        dna_valid   // Identifier captured
);

    dna_pkg::read_state_e  state;
    logic                  restart;
    logic                  busy;
    logic                  serial_bit;              // Port model to capture
    logic [`DNA_WIDTH-1:0] dna_value;

    // =========================================================================
    // Reader
    // =========================================================================
    dna_shift_if shift_bus ();

    dna_read_fsm u_fsm (
        .clk     (clk),
        .reset   (reset),
        .restart (restart),
        .ctl     (shift_bus.fsm),
        .state   (state)
    );

    dna_bit_counter u_counter (.clk(clk), .reset(reset), .ctl(shift_bus.counter));

    dna_capture_reg u_capture (
        .clk       (clk),
        .reset     (reset),
        .ctl       (shift_bus.capture),
        .serial_in (serial_bit),
        .dna_value (dna_value)
    );

    // Identity source, user-data input not modelled
    dna_port_model u_port (
        .clk        (clk),
        .read       (shift_bus.load),
        .shift      (shift_bus.shift),
        .serial_out (serial_bit)
    );

    assign busy      = (state != dna_pkg::DONE);   // Includes the load cycle
    assign dna_valid = shift_bus.done;

    // =========================================================================
    // Register slave
    // =========================================================================
    dna_axil_regs u_regs (
        .clk(clk), .reset(reset),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .dna_value(dna_value), .valid(shift_bus.done), .busy(busy), .restart(restart)
    );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ns

// Free-running clock and power-on reset
module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 4,
    parameter int unsigned RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;                      // Released on a rising edge
    end

endmodule

/* test/dna_id_tb.sv */
`timescale 1ns/1ns
`include "dna_cfg.svh"

module dna_id_tb;

    localparam int unsigned READ_CYCLES = 97;   // LOAD plus 96 shifts
    localparam int unsigned NUM_READS   = 2;    // Power-up read and one restart
    localparam int unsigned POLL_LIMIT  = 40;   // Status polls per wait
    localparam int unsigned NUM_TXNS    = 28 + 2 * POLL_LIMIT;
    localparam int unsigned WATCHDOG_CYCLES = 20 * (NUM_READS * READ_CYCLES + NUM_TXNS);
    localparam logic [`DNA_WIDTH-1:0] EXP_ID = `DNA_SIM_VALUE;

    logic clk;
    logic reset;
    logic [`AXIL_ADDR_WIDTH-1:0] awaddr;
    logic [`AXIL_ADDR_WIDTH-1:0] araddr;
    logic [`AXIL_DATA_WIDTH-1:0] wdata;
    logic [`AXIL_DATA_WIDTH-1:0] s_rdata;
    logic                        awvalid, wvalid, bready, arvalid, rready;
    logic                        s_awready, s_wready, s_bvalid, s_arready, s_rvalid;
    logic [1:0]                  s_bresp;
    logic [1:0]                  s_rresp;
    logic                        dna_valid;

    int unsigned value_errors    = 0;
    int unsigned protocol_errors = 0;
    int unsigned timing_errors   = 0;
    logic [31:0] rand_state      = 32'h819c_97b5;

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(5)) u_clock (.clk(clk), .reset(reset));

    dna_id_top UUT (
        .clk(clk), .reset(reset),
        .s_awaddr(awaddr), .s_awvalid(awvalid), .s_awready(s_awready),
        .s_wdata(wdata), .s_wvalid(wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(bready),
        .s_araddr(araddr), .s_arvalid(arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(rready),
        .dna_valid(dna_valid)
    );

    // =========================================================================
    // Helpers
    // =========================================================================
    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;   // Numerical Recipes LCG
        return rand_state;
    endfunction

    // Any non-word-aligned offset is outside the map
    function automatic logic [`AXIL_ADDR_WIDTH-1:0] unmapped_addr();
        logic [31:0] word;
        do begin
            word = next_random();
        end while (word[25:24] == 2'b00);
        return word[27:24];
    endfunction

    task automatic protocol_error(input string msg);
        protocol_errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("FAIL %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // =========================================================================
    // Bus transactions
    // =========================================================================
    int unsigned edge_count      = 0;   // Rising edges with reset low
    int unsigned ctrl_write_edge = 0;   // Edge of the last restart write

    task automatic write_reg(input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                             input logic [`AXIL_DATA_WIDTH-1:0] data, output logic [1:0] resp);
        int unsigned delay;
        delay = next_random() >> 30;            // 0..3 cycles of bready back-pressure
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        do @(posedge clk); while (!s_awready);  // Address and data taken together
        if (addr == `DNA_REG_CTRL_STATUS && data[0]) begin
            ctrl_write_edge = edge_count + 1;   // Counter update still pending
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (delay) @(posedge clk);
        bready <= 1'b1;
        do @(posedge clk); while (!s_bvalid);
        resp = s_bresp;
        bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                            output logic [`AXIL_DATA_WIDTH-1:0] data, output logic [1:0] resp);
        int unsigned delay;
        delay = next_random() >> 30;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!s_arready);
        arvalid <= 1'b0;
        repeat (delay) @(posedge clk);
        rready <= 1'b1;
        do @(posedge clk); while (!s_rvalid);
        data = s_rdata;
        resp = s_rresp;
        rready <= 1'b0;
    endtask

    task automatic check_read(input string what, input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] exp_data, input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        read_reg(addr, data, resp);
        check_value({what, " data"}, data, exp_data);
        check_value({what, " resp"}, resp, exp_resp);
    endtask

    task automatic check_write(input string what, input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                               input logic [31:0] data, input logic [1:0] exp_resp);
        logic [1:0] resp;
        write_reg(addr, data, resp);
        check_value({what, " resp"}, resp, exp_resp);
    endtask

    task automatic check_ids(input string when);
        check_read({"ID_LO ", when}, `DNA_REG_ID_LO, EXP_ID[31:0], dna_pkg::OKAY);
        check_read({"ID_MID ", when}, `DNA_REG_ID_MID, EXP_ID[63:32], dna_pkg::OKAY);
        check_read({"ID_HI ", when}, `DNA_REG_ID_HI, EXP_ID[95:64], dna_pkg::OKAY);
    endtask

    // Busy alone while reading and valid alone once done
    task automatic poll_valid();
        logic [31:0] data;
        logic [1:0]  resp;
        int unsigned polls = 0;
        do begin
            read_reg(`DNA_REG_CTRL_STATUS, data, resp);
            polls++;
            assert (resp == dna_pkg::OKAY && (data == 32'h1 || data == 32'h2)) else begin
                value_errors++;
                $display("FAIL %0t: status 0x%08h resp %0d during poll", $time, data, resp);
            end
        end while (!data[0] && polls < POLL_LIMIT);
        if (!data[0]) begin
            timing_errors++;
            $display("Valid bit still clear after %0d status polls", polls);
        end
    endtask

    // =========================================================================
    // Monitors
    // =========================================================================
    always @(posedge clk) begin
        edge_count <= reset ? 0 : edge_count + 1;
    end

    // Every valid rise comes READ_CYCLES after reset or after the last drop
    int unsigned fall_edge  = 0;
    int unsigned rise_count = 0;
    int unsigned fall_count = 0;
    logic        prev_valid = 1'b0;

    always @(negedge clk) begin
        if (reset) begin
            fall_edge  = 0;
            prev_valid = 1'b0;
        end else begin
            if (dna_valid && !prev_valid) begin
                rise_count++;
                assert (edge_count - fall_edge == READ_CYCLES) else begin
                    timing_errors++;
                    $display("FAIL %0t: valid rose %0d cycles after read start, expected %0d",
                             $time, edge_count - fall_edge, READ_CYCLES);
                end
            end
            if (!dna_valid && prev_valid) begin
                fall_count++;
                fall_edge = edge_count;
                assert (edge_count == ctrl_write_edge + 1) else begin
                    timing_errors++;
                    $display("FAIL %0t: valid fell at edge %0d, restart written at edge %0d",
                             $time, edge_count, ctrl_write_edge);
                end
            end
            prev_valid = dna_valid;
        end
    end

    // Handshake rules checked on pre-edge values
    logic                        b_waiting = 1'b0;
    logic                        r_waiting = 1'b0;
    logic [1:0]                  held_bresp;
    logic [1:0]                  held_rresp;
    logic [`AXIL_DATA_WIDTH-1:0] held_rdata;
    int                          w_open = 0;       // Accepted writes awaiting bready
    int                          r_open = 0;

    always @(posedge clk) begin
        if (!reset) begin
            assert (s_awready == s_wready) else protocol_error("awready and wready differ");
            if (b_waiting) begin
                assert (s_bvalid && s_bresp == held_bresp)
                    else protocol_error("write response not held until bready");
            end
            if (r_waiting) begin
                assert (s_rvalid && s_rdata == held_rdata && s_rresp == held_rresp)
                    else protocol_error("read response not held until rready");
            end
            if (s_bvalid) begin
                assert (!s_awready) else protocol_error("awready high with bvalid pending");
                assert (w_open == 1) else protocol_error("write response without a write");
            end
            if (s_rvalid) begin
                assert (!s_arready) else protocol_error("arready high with rvalid pending");
                assert (r_open == 1) else protocol_error("read response without a read");
            end
            if (s_awready && awvalid) w_open++;
            if (s_arready && arvalid) r_open++;
            if (s_bvalid && bready) w_open--;
            if (s_rvalid && rready) r_open--;
        end
        b_waiting  = s_bvalid && !bready;
        r_waiting  = s_rvalid && !rready;
        held_bresp = s_bresp;
        held_rresp = s_rresp;
        held_rdata = s_rdata;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the test did not complete", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // =========================================================================
    // Test sequence
    // =========================================================================
    initial begin
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        wait (reset === 1'b0);
        @(negedge clk);
        assert (!s_awready && !s_wready && !s_arready && !s_bvalid && !s_rvalid && !dna_valid)
            else protocol_error("control outputs active after reset");

        // Power-up read in progress and restart request ignored
        check_read("status while busy", `DNA_REG_CTRL_STATUS, 32'h2, dna_pkg::OKAY);
        check_read("ID_LO while busy", `DNA_REG_ID_LO, 32'h0, dna_pkg::OKAY);
        check_read("ID_MID while busy", `DNA_REG_ID_MID, 32'h0, dna_pkg::OKAY);
        check_read("ID_HI while busy", `DNA_REG_ID_HI, 32'h0, dna_pkg::OKAY);
        check_write("restart while busy", `DNA_REG_CTRL_STATUS, 32'h1, dna_pkg::OKAY);
        poll_valid();
        check_ids("after power-up");
        check_read("status when done", `DNA_REG_CTRL_STATUS, 32'h1, dna_pkg::OKAY);

        // Error responses
        repeat (8) check_read("unmapped read", unmapped_addr(), 32'h0, dna_pkg::SLVERR);
        check_write("ID_LO write", `DNA_REG_ID_LO, next_random(), dna_pkg::SLVERR);
        check_write("ID_MID write", `DNA_REG_ID_MID, next_random(), dna_pkg::SLVERR);
        check_write("ID_HI write", `DNA_REG_ID_HI, next_random(), dna_pkg::SLVERR);
        check_write("unmapped write", unmapped_addr(), 32'h1, dna_pkg::SLVERR);
        check_ids("after rejected writes");

        // Software re-read
        check_write("restart when done", `DNA_REG_CTRL_STATUS, 32'h1, dna_pkg::OKAY);
        poll_valid();
        check_ids("after restart");

        assert (rise_count == 2 && fall_count == 1) else begin
            timing_errors++;
            $display("FAIL %0t: %0d valid rises and %0d falls, expected 2 and 1",
                     $time, rise_count, fall_count);
        end
        $display("Errors: value %0d, protocol %0d, timing %0d",
                 value_errors, protocol_errors, timing_errors);
        if (value_errors + protocol_errors + timing_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+common
common/dna_pkg.sv
common/dna_shift_if.sv
dna_reader/dna_read_fsm.sv
dna_reader/dna_bit_counter.sv
dna_reader/dna_capture_reg.sv
src/dna_port_model.sv
src/dna_axil_regs.sv
src/dna_id_top.sv
test/tb_clock_gen.sv
test/dna_id_tb.sv

/* Bender.yml */
package:
  name: dna_id

sources:
  - include_dirs:
      - common
    files:
      - common/dna_pkg.sv
      - common/dna_shift_if.sv
      - dna_reader/dna_read_fsm.sv
      - dna_reader/dna_bit_counter.sv
      - dna_reader/dna_capture_reg.sv
      - src/dna_port_model.sv
      - src/dna_axil_regs.sv
      - src/dna_id_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_clock_gen.sv
      - test/dna_id_tb.sv
